// File: filelist.f
+incdir+hdl
hdl/mpu_bus_pkg.sv
hdl/mpu_region_pkg.sv
hdl/mpu_pma_lookup.sv
hdl/mpu_pmp_csr.sv
hdl/mpu_access_resolve.sv
hdl/mpu_top.sv
testbench/mpu_chk.sv
testbench/mpu_tb.sv

// File: hdl/mpu_access_resolve.sv
/*
  Merges the PMA and PMP results into one access response
  and registers it with its valid bit
*/

module mpu_access_resolve (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid_i,
  input  mpu_region_pkg::pma_res_t pma_res_i,
  input  mpu_region_pkg::pmp_res_t pmp_res_i,
  output logic                     resp_valid_o,
  output mpu_bus_pkg::mpu_resp_t   resp_o
);

  import mpu_bus_pkg::*;

  mpu_resp_t resp_d;
  mpu_resp_t resp_q;
  logic      resp_valid_q;

  always_comb begin
    // Debug-module accesses bypass PMP
    resp_d.pmp_err    = pmp_res_i.err && !pma_res_i.dm_hit;
    resp_d.pma_err    = pma_res_i.err;
    resp_d.err        = resp_d.pma_err || resp_d.pmp_err;
    resp_d.cacheable  = pma_res_i.cacheable;
    resp_d.bufferable = pma_res_i.bufferable;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
    end
  end

  // Payload only follows accepted requests
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// File: hdl/mpu_bus_pkg.sv
/*
  Access request and response types
  APB register map offsets of the PMP register file
*/

`include "mpu_settings.svh"

package mpu_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Access side
  //////////////////////////////////////////////////////////////////////

  // One access as presented by the core, 36 bits
  typedef struct packed {
    logic [31:0] addr;
    logic        dbg;
    logic        instr;
    logic        write;
    logic        misaligned;
  } mpu_req_t;

  // Result of an access, returned one cycle after the request
  typedef struct packed {
    logic err;
    logic pma_err;
    logic pmp_err;
    logic cacheable;
    logic bufferable;
  } mpu_resp_t;

  //////////////////////////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////////////////////////

  // pmpcfg i lives at PMPCFG_BASE + 4*i
  localparam logic [`MPU_APB_AW-1:0] PMPCFG_BASE = 'h00;

  // pmpaddr i lives at PMPADDR_BASE + 4*i, holds a word address
  localparam logic [`MPU_APB_AW-1:0] PMPADDR_BASE = 'h20;

  // Security config, rlb in bit 2 and mmwp in bit 1
  localparam logic [`MPU_APB_AW-1:0] MSECCFG_OFS = 'h40;

endpackage

// File: hdl/mpu_pma_lookup.sv
/*
  PMA attribute lookup
  Lowest-match search over the fixed table, debug-module override
  and the PMA error rule, all combinational
*/

`include "mpu_settings.svh"

module mpu_pma_lookup (
  input  mpu_bus_pkg::mpu_req_t    req_i,
  output mpu_region_pkg::pma_res_t pma_res_o
);

  import mpu_region_pkg::*;

  logic [29:0] word_addr;
  logic        dm_hit;
  logic        matched;
  pma_cfg_t    cfg;

  assign word_addr = req_i.addr[31:2];

  // Debug accesses into the debug module are always let through
  assign dm_hit = req_i.dbg &&
                  (req_i.addr >= `MPU_DM_START) &&
                  (req_i.addr <= `MPU_DM_END);

  //////////////////////////////////////////////////////////////////////
  // Region select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cfg     = PMA_DEFAULT;
    matched = 1'b0;

    // First hit wins, later regions are shadowed
    for (int i = 0; i < `MPU_PMA_REGIONS; i++) begin
      if (!matched &&
          (PMA_TABLE[i].word_addr_low <= word_addr) &&
          (word_addr < PMA_TABLE[i].word_addr_high)) begin
        cfg     = PMA_TABLE[i];
        matched = 1'b1;
      end
    end

    if (dm_hit) begin
      cfg      = '0;
      cfg.main = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////

  // Fetches and misaligned accesses need main memory
  assign pma_res_o.err = !cfg.main && (req_i.instr || req_i.misaligned);

  assign pma_res_o.cacheable = cfg.cacheable;

  // Only writes may be posted
  assign pma_res_o.bufferable = cfg.bufferable && req_i.write;

  assign pma_res_o.dm_hit = dm_hit;

endmodule

// File: hdl/mpu_pmp_csr.sv
/*
  PMP register file behind an APB slave port
  Config, address and security registers with the lock rules
  TOR permission check for the current access
*/

`include "mpu_settings.svh"

module mpu_pmp_csr (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`MPU_APB_AW-1:0]   paddr_i,
  input  logic [31:0]              pwdata_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  mpu_bus_pkg::mpu_req_t    req_i,
  output mpu_region_pkg::pmp_res_t pmp_res_o
);

  import mpu_bus_pkg::*;
  import mpu_region_pkg::*;

  localparam int NR = `MPU_PMP_REGIONS;
  localparam int AW = `MPU_APB_AW;

  pmp_cfg_t    cfg_q [NR];
  logic [31:0] addr_q [NR];
  mseccfg_t    mseccfg_q;
  logic        rlb_locked_q;

  logic          access;
  logic          apb_wr;
  logic [NR-1:0] cfg_sel;
  logic [NR-1:0] addr_sel;
  logic          sec_sel;
  logic [NR-1:0] cfg_locked;
  logic [NR-1:0] addr_locked;
  logic          any_lock;
  logic          rlb_lock_now;
  pmp_cfg_t      cfg_wdata;
  logic          cfg_wr_rsvd;

  //////////////////////////////////////////////////////////////////////
  // APB decode
  //////////////////////////////////////////////////////////////////////

  assign access = psel_i && penable_i;
  assign apb_wr = access && pwrite_i;

  always_comb begin
    for (int i = 0; i < NR; i++) begin
      cfg_sel[i]  = paddr_i == AW'(PMPCFG_BASE + 4 * i);
      addr_sel[i] = paddr_i == AW'(PMPADDR_BASE + 4 * i);
    end
    sec_sel = paddr_i == MSECCFG_OFS;
  end

  // Zero wait states
  assign pready_o  = access;
  assign pslverr_o = access && !(|cfg_sel || |addr_sel || sec_sel);

  always_comb begin
    prdata_o = '0;
    for (int i = 0; i < NR; i++) begin
      if (cfg_sel[i]) prdata_o = {24'h0, cfg_q[i]};
      if (addr_sel[i]) prdata_o = addr_q[i];
    end
    if (sec_sel) prdata_o = {29'h0, mseccfg_q.rlb, mseccfg_q.mmwp, 1'b0};
  end

  //////////////////////////////////////////////////////////////////////
  // Lock rules
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < NR; i++) begin
      cfg_locked[i]  = cfg_q[i].lock && !mseccfg_q.rlb;
      addr_locked[i] = cfg_locked[i];
      // TOR region i+1 uses addr i as its lower bound
      if (i < NR - 1) begin
        addr_locked[i] = addr_locked[i] ||
                         (cfg_q[i+1].lock && (cfg_q[i+1].mode == PMP_TOR) && !mseccfg_q.rlb);
      end
      any_lock = any_lock || cfg_q[i].lock;
    end
  end

  assign rlb_lock_now = rlb_locked_q || (any_lock && !mseccfg_q.rlb);

  always_comb begin
    cfg_wdata      = pmp_cfg_t'(pwdata_i[7:0]);
    cfg_wdata.rsvd = 2'b00;
  end

  // RW=01 is reserved, such a write is dropped
  assign cfg_wr_rsvd = !cfg_wdata.read && cfg_wdata.write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NR; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
      mseccfg_q    <= '0;
      rlb_locked_q <= 1'b0;
    end else begin
      rlb_locked_q <= rlb_lock_now;
      if (apb_wr) begin
        for (int i = 0; i < NR; i++) begin
          if (cfg_sel[i] && !cfg_locked[i] && !cfg_wr_rsvd) begin
            cfg_q[i] <= cfg_wdata;
          end
          if (addr_sel[i] && !addr_locked[i]) begin
            addr_q[i] <= pwdata_i;
          end
        end
        if (sec_sel) begin
          mseccfg_q.rlb  <= pwdata_i[2] && !rlb_lock_now;
          mseccfg_q.mmwp <= mseccfg_q.mmwp || pwdata_i[1];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TOR permission check
  //////////////////////////////////////////////////////////////////////

  logic [31:0] word_addr;
  logic        found;
  logic [31:0] lower;

  assign word_addr = {2'b00, req_i.addr[31:2]};

  always_comb begin
    found         = 1'b0;
    pmp_res_o.err = mseccfg_q.mmwp;
    for (int i = 0; i < NR; i++) begin
      lower = (i == 0) ? 32'h0 : addr_q[(i == 0) ? 0 : i - 1];
      if (!found && (cfg_q[i].mode == PMP_TOR) &&
          (lower <= word_addr) && (word_addr < addr_q[i])) begin
        found = 1'b1;
        // Unlocked regions do not restrict machine mode
        if (!cfg_q[i].lock) pmp_res_o.err = 1'b0;
        else if (req_i.instr) pmp_res_o.err = !cfg_q[i].exec;
        else if (req_i.write) pmp_res_o.err = !cfg_q[i].write;
        else pmp_res_o.err = !cfg_q[i].read;
      end
    end
  end

endmodule

// File: hdl/mpu_region_pkg.sv
/*
  PMA and PMP configuration types
  PMP mode encoding and the fixed PMA region table
*/

`include "mpu_settings.svh"

package mpu_region_pkg;

  //////////////////////////////////////////////////////////////////////
  // PMA
  //////////////////////////////////////////////////////////////////////

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
  } pma_cfg_t;

  // Region 3 overlaps region 0, region 0 must win there
  localparam pma_cfg_t PMA_TABLE [`MPU_PMA_REGIONS] = '{
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1},
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0C00_0000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0},
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h2400_0000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1}
  };

  // Unmatched addresses are plain I/O
  localparam pma_cfg_t PMA_DEFAULT = '0;

  typedef struct packed {
    logic err;
    logic cacheable;
    logic bufferable;
    logic dm_hit;
  } pma_res_t;

  //////////////////////////////////////////////////////////////////////
  // PMP
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PMP_OFF = 2'b00,
    PMP_TOR = 2'b01
  } pmp_mode_e;

  // Matches the pmpcfg byte layout
  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef struct packed {
    logic rlb;
    logic mmwp;
  } mseccfg_t;

  typedef struct packed {
    logic err;
  } pmp_res_t;

endpackage

// File: hdl/mpu_settings.svh
/*
  Build settings for the memory protection unit
  Region counts, debug-module window and APB address width
*/

`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// Number of entries in the fixed PMA table
`define MPU_PMA_REGIONS 4

// Number of software-programmed PMP regions
`define MPU_PMP_REGIONS 4

// Debug-module window, both bounds inclusive
`define MPU_DM_START 32'hF000_0000
`define MPU_DM_END   32'hF000_3FFF

// APB address width in bits
`define MPU_APB_AW 8

`endif

// File: hdl/mpu_top.sv
/*
  Memory protection unit top level
  PMA lookup and PMP register file feed one response stage
*/

`include "mpu_settings.svh"

module mpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  mpu_bus_pkg::mpu_req_t  req_i,
  output logic                   resp_valid_o,
  output mpu_bus_pkg::mpu_resp_t resp_o,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`MPU_APB_AW-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  import mpu_region_pkg::*;

  pma_res_t pma_res;
  pmp_res_t pmp_res;

  mpu_pma_lookup u_pma_lookup (
    .req_i     (req_i),
    .pma_res_o (pma_res)
  );

  mpu_pmp_csr u_pmp_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .req_i     (req_i),
    .pmp_res_o (pmp_res)
  );

  mpu_access_resolve u_access_resolve (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .pma_res_i    (pma_res),
    .pmp_res_i    (pmp_res),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the MPU simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing \
  -f filelist.f \
  --top-module mpu_tb \
  --Mdir obj_dir \
  -o mpu_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mpu_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

exit 0

// File: testbench/mpu_chk.sv
/*
  Concurrent assertions on the memory protection unit
  Response timing, debug-module responses, sticky mmwp, APB ready
*/

module mpu_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   req_valid_i,
  input logic                   resp_valid_i,
  input mpu_bus_pkg::mpu_resp_t resp_i,
  input logic                   dm_hit_i,
  input logic                   mmwp_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pready_i
);

  // Every accepted request gets its response on the next edge
  a_resp_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n) req_valid_i |=> resp_valid_i
  ) else $error("response missing one cycle after an accepted request");

  a_no_resp_without_req: assert property (
    @(posedge clk) disable iff (!rst_n) !req_valid_i |=> !resp_valid_i
  ) else $error("response without an accepted request");

  // Debug-module accesses are always let through
  a_dm_hit_no_err: assert property (
    @(posedge clk) disable iff (!rst_n) (req_valid_i && dm_hit_i) |=> !resp_i.err
  ) else $error("debug-module access reported an error");

  a_mmwp_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) mmwp_i |=> mmwp_i
  ) else $error("mmwp was cleared");

  a_ready_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pready_i |-> (psel_i && penable_i)
  ) else $error("pready outside the APB access phase");

endmodule

bind mpu_top mpu_chk u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_valid_i  (req_valid_i),
  .resp_valid_i (resp_valid_o),
  .resp_i       (resp_o),
  .dm_hit_i     (pma_res.dm_hit),
  .mmwp_i       (u_pmp_csr.mseccfg_q.mmwp),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pready_i     (pready_o)
);

// File: testbench/mpu_tb.sv
/*
  Directed testbench for the memory protection unit
  APB tasks, compare tasks, reference model of PMA and PMP rules,
  directed tests, pipelined random traffic and a watchdog
*/

`include "mpu_settings.svh"

module mpu_tb;

  import mpu_bus_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int RAND_REQS   = 500;
  localparam int TEST_CYCLES = RAND_REQS + 600;
  localparam int WATCHDOG    = TEST_CYCLES * CLK_PERIOD + 1600;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  mpu_req_t               req;
  logic                   resp_valid;
  mpu_resp_t              resp;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`MPU_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  // Shadow copy of the PMP registers
  logic [7:0]  sh_cfg [4];
  logic [31:0] sh_addr [4];
  logic        sh_rlb;
  logic        sh_mmwp;
  logic        sh_rlb_locked;

  mpu_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    abort_run("Watchdog expired before the tests completed");
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and compare
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_resp(input string name, input mpu_resp_t exp, input mpu_resp_t act);
    if (exp !== act) begin
      $display("ERROR %s: expected %b actual %b", name, exp, act);
      abort_run("Response mismatch");
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h actual %h", name, exp, act);
      abort_run("Register readback mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic mpu_resp_t expect_resp(input mpu_req_t r);
    mpu_resp_t   e;
    logic        main;
    logic        cach;
    logic        bufb;
    logic        dm;
    logic        perr;
    logic        found;
    logic [31:0] w;
    logic [31:0] lo;
    main = 1'b0;
    cach = 1'b0;
    bufb = 1'b0;
    dm   = r.dbg && (r.addr >= 32'hF000_0000) && (r.addr <= 32'hF000_3FFF);
    if (dm) begin
      main = 1'b1;
    end else if (r.addr < 32'h0001_0000) begin
      main = 1'b1;
      cach = 1'b1;
    end else if (r.addr >= 32'h1000_0000 && r.addr < 32'h1000_1000) begin
      main = 1'b0;
    end else if (r.addr >= 32'h2000_0000 && r.addr < 32'h3000_0000) begin
      main = 1'b1;
      bufb = 1'b1;
    end else if (r.addr >= 32'h0000_8000 && r.addr < 32'h9000_0000) begin
      main = 1'b1;
      cach = 1'b1;
      bufb = 1'b1;
    end
    w     = r.addr >> 2;
    perr  = sh_mmwp;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      lo = 32'h0;
      if (i > 0) lo = sh_addr[i-1];
      if (!found && sh_cfg[i][4:3] == 2'b01 && lo <= w && w < sh_addr[i]) begin
        found = 1'b1;
        if (!sh_cfg[i][7]) perr = 1'b0;
        else if (r.instr) perr = !sh_cfg[i][2];
        else if (r.write) perr = !sh_cfg[i][1];
        else perr = !sh_cfg[i][0];
      end
    end
    e.pma_err    = !main && (r.instr || r.misaligned);
    e.pmp_err    = perr && !dm;
    e.err        = e.pma_err || e.pmp_err;
    e.cacheable  = cach;
    e.bufferable = bufb && r.write;
    return e;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] a);
    logic [31:0] d;
    d = 32'h0;
    for (int i = 0; i < 4; i++) begin
      if (a == 8'(4 * i)) d = {24'h0, sh_cfg[i]};
      if (a == 8'(32 + 4 * i)) d = sh_addr[i];
    end
    if (a == 8'h40) d = {29'h0, sh_rlb, sh_mmwp, 1'b0};
    return d;
  endfunction

  task automatic model_write(input logic [7:0] a, input logic [31:0] d);
    logic any;
    logic locked;
    any = 1'b0;
    for (int i = 0; i < 4; i++) any = any || sh_cfg[i][7];
    sh_rlb_locked = sh_rlb_locked || (any && !sh_rlb);
    for (int i = 0; i < 4; i++) begin
      if (a == 8'(4 * i) && !(sh_cfg[i][7] && !sh_rlb) && !(!d[0] && d[1])) begin
        sh_cfg[i] = d[7:0] & 8'h9F;
      end
      if (a == 8'(32 + 4 * i)) begin
        locked = sh_cfg[i][7] && !sh_rlb;
        if (i < 3) begin
          if (sh_cfg[i+1][7] && sh_cfg[i+1][4:3] == 2'b01 && !sh_rlb) locked = 1'b1;
        end
        if (!locked) sh_addr[i] = d;
      end
    end
    if (a == 8'h40) begin
      sh_rlb  = d[2] && !sh_rlb_locked;
      sh_mmwp = sh_mmwp || d[1];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic do_reset;
    rst_n = 1'b0;
    for (int i = 0; i < 4; i++) begin
      sh_cfg[i]  = 8'h0;
      sh_addr[i] = 32'h0;
    end
    sh_rlb        = 1'b0;
    sh_mmwp       = 1'b0;
    sh_rlb_locked = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output logic err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    // Access phase ends at the next rising edge with pready high
    @(posedge clk);
    while (!pready) begin
      if (waited > 16) abort_run("APB slave never raised pready");
      @(posedge clk);
      waited++;
    end
    rd  = prdata;
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
    logic [31:0] unused_rd;
    apb_access(1'b1, a, d, unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
    apb_access(1'b0, a, 32'h0, d, err);
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
    logic err;
    apb_write(a, d, err);
    if (err) abort_run("Unexpected pslverr on a mapped register write");
    model_write(a, d);
  endtask

  task automatic check_reg(input string name, input logic [7:0] a);
    logic [31:0] d;
    logic        err;
    apb_read(a, d, err);
    if (err) abort_run("Unexpected pslverr on a mapped register read");
    compare_word(name, model_read(a), d);
  endtask

  task automatic send_req(input string name, input logic [31:0] addr, input logic dbg,
                          input logic instr, input logic write, input logic mis);
    mpu_req_t r;
    r.addr       = addr;
    r.dbg        = dbg;
    r.instr      = instr;
    r.write      = write;
    r.misaligned = mis;
    @(negedge clk);
    req_valid = 1'b1;
    req       = r;
    @(negedge clk);
    req_valid = 1'b0;
    if (!resp_valid) abort_run("No response one cycle after the request");
    compare_resp(name, expect_resp(r), resp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_pma_attrs;
    send_req("pma_r0_read", 32'h0000_0100, 0, 0, 0, 0);
    send_req("pma_overlap", 32'h0000_9000, 0, 0, 1, 0);
    send_req("pma_r1_io", 32'h1000_0010, 0, 0, 1, 0);
    send_req("pma_r2_write", 32'h2000_0040, 0, 0, 1, 0);
    send_req("pma_r2_read", 32'h2000_0040, 0, 0, 0, 0);
    send_req("pma_r3_write", 32'h0100_0000, 0, 0, 1, 0);
    send_req("pma_none", 32'hA000_0000, 0, 0, 1, 0);
    send_req("pma_r3_edge", 32'h9000_0000, 0, 0, 0, 0);
  endtask

  task automatic test_pma_errors;
    send_req("io_fetch", 32'h1000_0000, 0, 1, 0, 0);
    send_req("io_misaligned", 32'hA000_0000, 0, 0, 1, 1);
    send_req("main_fetch", 32'h0000_0200, 0, 1, 0, 0);
    send_req("dm_dbg_fetch", 32'hF000_0100, 1, 1, 0, 0);
    send_req("dm_nodbg_fetch", 32'hF000_0100, 0, 1, 0, 0);
  endtask

  task automatic test_apb_regs;
    logic [31:0] d;
    logic        err;
    write_reg(8'h00, 32'h0000_000F);
    check_reg("cfg0_rw", 8'h00);
    write_reg(8'h00, 32'h0000_0062);
    check_reg("cfg0_rw01", 8'h00);
    write_reg(8'h04, 32'h0000_006B);
    check_reg("cfg1_rsvd", 8'h04);
    write_reg(8'h2C, 32'h1234_5678);
    check_reg("addr3_rw", 8'h2C);
    check_reg("mseccfg_reset", 8'h40);
    apb_read(8'h80, d, err);
    if (!err) abort_run("Unmapped read did not raise pslverr");
    apb_write(8'h44, 32'hFFFF_FFFF, err);
    if (!err) abort_run("Unmapped write did not raise pslverr");
    write_reg(8'h00, 32'h0);
    write_reg(8'h04, 32'h0);
    write_reg(8'h2C, 32'h0);
  endtask

  task automatic test_pmp_enforce;
    write_reg(8'h20, 32'h0000_0400);
    write_reg(8'h24, 32'h0000_0800);
    write_reg(8'h00, 32'h0000_0089);
    write_reg(8'h04, 32'h0000_0008);
    send_req("pmp_lk_read", 32'h0000_0100, 0, 0, 0, 0);
    send_req("pmp_lk_write", 32'h0000_0100, 0, 0, 1, 0);
    send_req("pmp_lk_fetch", 32'h0000_0100, 0, 1, 0, 0);
    send_req("pmp_unlk_write", 32'h0000_1100, 0, 0, 1, 0);
    send_req("pmp_nomatch", 32'h0000_3000, 0, 0, 1, 0);
    write_reg(8'h04, 32'h0000_008C);
    send_req("pmp_x_fetch", 32'h0000_1100, 0, 1, 0, 0);
    send_req("pmp_x_read", 32'h0000_1100, 0, 0, 0, 0);
    write_reg(8'h20, 32'h0000_0100);
    write_reg(8'h24, 32'h0000_0100);
    write_reg(8'h04, 32'h0000_000F);
    write_reg(8'h00, 32'h0000_000F);
    write_reg(8'h28, 32'h0000_0C00);
    check_reg("addr0_tor_lock", 8'h20);
    check_reg("addr1_lock", 8'h24);
    check_reg("cfg1_lock", 8'h04);
    check_reg("cfg0_lock", 8'h00);
    check_reg("addr2_free", 8'h28);
    // Region 2 stays unlocked, only the locked TOR region 3 guards addr 2
    write_reg(8'h0C, 32'h0000_0088);
    write_reg(8'h28, 32'h0000_0D00);
    check_reg("addr2_tor_lock", 8'h28);
  endtask

  task automatic test_rlb_mmwp;
    write_reg(8'h40, 32'h4);
    check_reg("rlb_set", 8'h40);
    write_reg(8'h20, 32'h0000_2000);
    write_reg(8'h00, 32'h0000_008D);
    write_reg(8'h00, 32'h0000_008F);
    check_reg("cfg0_rlb_write", 8'h00);
    write_reg(8'h20, 32'h0000_1000);
    check_reg("addr0_rlb_write", 8'h20);
    write_reg(8'h40, 32'h0);
    check_reg("rlb_clear", 8'h40);
    write_reg(8'h00, 32'h0000_008D);
    check_reg("cfg0_relocked", 8'h00);
    write_reg(8'h40, 32'h4);
    check_reg("rlb_denied", 8'h40);
    send_req("rlb_region_write", 32'h0000_0100, 0, 0, 1, 0);
    write_reg(8'h40, 32'h2);
    write_reg(8'h40, 32'h0);
    check_reg("mmwp_sticky", 8'h40);
    send_req("mmwp_nomatch", 32'hA000_0000, 0, 0, 0, 0);
    send_req("mmwp_match", 32'h0000_0100, 0, 0, 0, 0);
  endtask

  task automatic test_random_traffic;
    mpu_req_t  r;
    mpu_resp_t prev_exp;
    for (int n = 0; n <= RAND_REQS; n++) begin
      @(negedge clk);
      if (n > 0) begin
        if (!resp_valid) abort_run("Missing response in back-to-back traffic");
        compare_resp("random", prev_exp, resp);
      end
      if (n < RAND_REQS) begin
        case ($urandom % 4)
          0: r.addr = $urandom % 32'h0002_0000;
          1: r.addr = 32'h1000_0000 + ($urandom % 32'h2000);
          2: r.addr = 32'hF000_0000 + ($urandom % 32'h8000);
          default: r.addr = $urandom;
        endcase
        r.dbg        = 1'($urandom);
        r.instr      = 1'($urandom);
        r.write      = 1'($urandom);
        r.misaligned = 1'($urandom);
        req_valid    = 1'b1;
        req          = r;
        prev_exp     = expect_resp(r);
      end else begin
        req_valid = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2af63b83));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    do_reset();
    test_pma_attrs();
    test_pma_errors();
    test_apb_regs();
    test_pmp_enforce();
    do_reset();
    test_rlb_mmwp();
    test_random_traffic();
    $display("Everything OK");
    $finish;
  end

endmodule
